// File: hdl/net_req_pkg.sv
/*
 * Network request types.
 * Stream codes, field widths and the single and paired request descriptors
 * shared by the host-side arbiter, the steering block and the register slices.
 */

package net_req_pkg;

  // Field widths.
  localparam int STRM_BITS  = 2;  // Stream kind.
  localparam int VADDR_BITS = 48; // Virtual address.
  localparam int LEN_BITS   = 28; // Transfer length in bytes.
  localparam int VFID_BITS  = 4;  // vFPGA identifier.
  localparam int DEST_BITS  = 4;  // Destination or session index.

  // Stream kinds carried in every descriptor.
  typedef enum logic [STRM_BITS-1:0] {
    STRM_CARD = 2'd0, // Card memory.
    STRM_HOST = 2'd1, // Host memory.
    STRM_TCP  = 2'd2, // TCP stack.
    STRM_RDMA = 2'd3  // RDMA stack.
  } strm_t;

  // Single descriptor of 87 bits.
  typedef struct packed {
    strm_t                 strm;  // Target stream.
    logic [VFID_BITS-1:0]  vfid;  // Issuing vFPGA.
    logic [DEST_BITS-1:0]  dest;  // Destination or session.
    logic [VADDR_BITS-1:0] vaddr; // Start address.
    logic [LEN_BITS-1:0]   len;   // Length.
    logic                  last;  // Last request of a transfer.
  } req_t;

  // Paired request of 174 bits.
  // req_1 describes the local buffer, req_2 the network side.
  typedef struct packed {
    req_t req_1; // Local descriptor.
    req_t req_2; // Network descriptor carrying the steering stream.
  } dreq_t;

endpackage

// File: hdl/meta_reg.sv
/*
 * Register slice for valid/ready metadata.
 * Two entries, a main and a spill register, give one transfer per cycle
 * with a registered input ready. Payload type is a parameter.
 */

`timescale 1ns/1ps

module meta_reg #(
  parameter type T = logic [7:0] // Payload type.
) (
  input  logic aclk,
  input  logic arst_n,
  // Upstream side.
  input  logic s_valid,
  output logic s_ready,
  input  T     s_data,
  // Downstream side.
  output logic m_valid,
  input  logic m_ready,
  output T     m_data
);

  logic spill_valid; // Spill entry occupied means the slice is full.
  T     spill_data;  // Spill payload.
  T     main_data;   // Output payload.
  logic load_main;   // Main register takes new data.
  logic load_spill;  // Input parks in the spill register.

  // Ready comes straight from a flop.
  assign s_ready = ~spill_valid;

  // Main is free when empty or draining this cycle.
  assign load_main  = (~m_valid | m_ready) & (spill_valid | s_valid);
  assign load_spill = m_valid & ~m_ready & s_valid & s_ready; // Stalled output parks input.

  // Control state.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid     <= 1'b0;
      spill_valid <= 1'b0;
    end else begin
      if (~m_valid | m_ready) begin
        m_valid     <= spill_valid | s_valid; // Spill has precedence.
        spill_valid <= 1'b0;                  // Spill always drains first.
      end else if (load_spill) begin
        spill_valid <= 1'b1;
      end
    end
  end

  // Payload.
  always_ff @(posedge aclk) begin
    if (load_main) main_data <= spill_valid ? spill_data : s_data;
    if (load_spill) spill_data <= s_data;
  end

  assign m_data = main_data;

  // Output is held while stalled.
  assert property (@(posedge aclk) disable iff (!arst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("meta_reg output changed while stalled");

  // A full slice always holds a main entry and takes no input.
  assert property (@(posedge aclk) disable iff (!arst_n)
    spill_valid |-> m_valid && !(s_valid && s_ready))
    else $error("meta_reg accepted input while full");

endmodule

// File: hdl/dreq_arb_2_1.sv
/*
 * Two-to-one round-robin arbiter for paired host requests.
 * Grant is combinational and locked while the granted request waits.
 */

`timescale 1ns/1ps

module dreq_arb_2_1 (
  input  logic               aclk,
  input  logic               arst_n,
  // Host port 0.
  input  logic               s_req_0_valid,
  output logic               s_req_0_ready,
  input  net_req_pkg::dreq_t s_req_0_data,
  // Host port 1.
  input  logic               s_req_1_valid,
  output logic               s_req_1_ready,
  input  net_req_pkg::dreq_t s_req_1_data,
  // Merged stream.
  output logic               m_valid,
  input  logic               m_ready,
  output net_req_pkg::dreq_t m_data
);

  logic prio;    // Source holding priority.
  logic lock;    // A granted request is waiting.
  logic grant_q; // Grant held during lock.
  logic grant;   // Current grant, 0 or 1.
  logic xfer;    // Transfer on the merged stream.

  // Grant selection.
  always_comb begin
    if (lock) begin
      grant = grant_q; // Never switch an open offer.
    end else if (prio) begin
      grant = s_req_1_valid ? 1'b1 : 1'b0;
    end else begin
      grant = s_req_0_valid ? 1'b0 : 1'b1;
    end
  end

  // Merged output.
  assign m_valid = grant ? s_req_1_valid : s_req_0_valid;
  assign m_data  = grant ? s_req_1_data : s_req_0_data;
  assign xfer    = m_valid & m_ready;

  // Ready only to the granted source.
  assign s_req_0_ready = ~grant & m_ready;
  assign s_req_1_ready = grant & m_ready;

  // Priority and lock.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      prio    <= 1'b0; // Source 0 first.
      lock    <= 1'b0;
      grant_q <= 1'b0;
    end else begin
      if (xfer) begin
        prio <= ~grant; // Served source loses priority.
        lock <= 1'b0;
      end else if (m_valid) begin
        lock    <= 1'b1; // Hold a stalled offer.
        grant_q <= grant;
      end
    end
  end

  // One source served at a time.
  assert property (@(posedge aclk) disable iff (!arst_n)
    !(s_req_0_ready && s_req_1_ready))
    else $error("dreq_arb_2_1 both readies high");

endmodule

// File: hdl/dreq_mux_net_1_2.sv
/*
 * Network request steering.
 * RDMA requests go out whole on port 0, every other stream
 * goes out as its network descriptor on port 1.
 */

`timescale 1ns/1ps

module dreq_mux_net_1_2 (
  input  logic               aclk,
  input  logic               arst_n,
  // Host request stream.
  input  logic               s_req_valid,
  output logic               s_req_ready,
  input  net_req_pkg::dreq_t s_req_data,
  // RDMA write.
  output logic               m_req_0_valid,
  input  logic               m_req_0_ready,
  output net_req_pkg::dreq_t m_req_0_data,
  // TCP write.
  output logic               m_req_1_valid,
  input  logic               m_req_1_ready,
  output net_req_pkg::req_t  m_req_1_data
);

  import net_req_pkg::*;

  logic  req_int_0_valid;
  logic  req_int_0_ready;
  dreq_t req_int_0_data;
  logic  req_int_1_valid;
  logic  req_int_1_ready;
  req_t  req_int_1_data;
  logic  is_rdma;

  assign is_rdma = (s_req_data.req_2.strm == STRM_RDMA); // Steer on network stream.

  // Route valid forward, ready back from the chosen slice.
  assign req_int_0_valid = s_req_valid & is_rdma;
  assign req_int_1_valid = s_req_valid & ~is_rdma;
  assign s_req_ready     = is_rdma ? req_int_0_ready : req_int_1_ready;

  assign req_int_0_data = s_req_data;       // Full pair.
  assign req_int_1_data = s_req_data.req_2; // Network side only.

  // RDMA slice.
  meta_reg #(.T(dreq_t)) inst_reg_0 (
    .aclk(aclk), .arst_n(arst_n),
    .s_valid(req_int_0_valid), .s_ready(req_int_0_ready), .s_data(req_int_0_data),
    .m_valid(m_req_0_valid), .m_ready(m_req_0_ready), .m_data(m_req_0_data)
  );

  // TCP slice.
  meta_reg #(.T(req_t)) inst_reg_1 (
    .aclk(aclk), .arst_n(arst_n),
    .s_valid(req_int_1_valid), .s_ready(req_int_1_ready), .s_data(req_int_1_data),
    .m_valid(m_req_1_valid), .m_ready(m_req_1_ready), .m_data(m_req_1_data)
  );

  // A request is steered to one path only.
  assert property (@(posedge aclk) disable iff (!arst_n)
    !(req_int_0_valid && req_int_1_valid))
    else $error("dreq_mux_net_1_2 request on both paths");

endmodule

// File: hdl/net_req_top.sv
/*
 * Request steering stage.
 * Merges two host request ports and steers each request
 * to the RDMA or the TCP write path.
 */

`timescale 1ns/1ps

module net_req_top (
  input  logic               aclk,
  input  logic               arst_n,
  // Host port 0.
  input  logic               s_req_0_valid,
  output logic               s_req_0_ready,
  input  net_req_pkg::dreq_t s_req_0_data,
  // Host port 1.
  input  logic               s_req_1_valid,
  output logic               s_req_1_ready,
  input  net_req_pkg::dreq_t s_req_1_data,
  // RDMA write.
  output logic               m_req_0_valid,
  input  logic               m_req_0_ready,
  output net_req_pkg::dreq_t m_req_0_data,
  // TCP write.
  output logic               m_req_1_valid,
  input  logic               m_req_1_ready,
  output net_req_pkg::req_t  m_req_1_data
);

  import net_req_pkg::*;

  // Combinational merged stream.
  logic  arb_valid;
  logic  arb_ready;
  dreq_t arb_data;

  // Round-robin merge of host ports.
  dreq_arb_2_1 inst_arb (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .s_req_0_valid (s_req_0_valid),
    .s_req_0_ready (s_req_0_ready),
    .s_req_0_data  (s_req_0_data),
    .s_req_1_valid (s_req_1_valid),
    .s_req_1_ready (s_req_1_ready),
    .s_req_1_data  (s_req_1_data),
    .m_valid       (arb_valid),
    .m_ready       (arb_ready),
    .m_data        (arb_data)
  );

  // Stream steering with output slices.
  dreq_mux_net_1_2 inst_mux (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .s_req_valid   (arb_valid),
    .s_req_ready   (arb_ready),
    .s_req_data    (arb_data),
    .m_req_0_valid (m_req_0_valid),
    .m_req_0_ready (m_req_0_ready),
    .m_req_0_data  (m_req_0_data),
    .m_req_1_valid (m_req_1_valid),
    .m_req_1_ready (m_req_1_ready),
    .m_req_1_data  (m_req_1_data)
  );

endmodule

// File: verification/net_req_model.svh
/*
 * Reference model for the request steering stage.
 * Expected queues per destination and the round-robin prediction.
 */

`ifndef NET_REQ_MODEL_SVH
`define NET_REQ_MODEL_SVH

dreq_t exp_rdma_q [$]; // Pairs due on the RDMA port.
req_t  exp_tcp_q [$];  // Network descriptors due on the TCP port.
bit    rr_next;        // Source expected to win next under full load.

// Accepted host request goes to the queue of its destination.
task automatic log_host(input dreq_t d);
  if (d.req_2.strm == STRM_RDMA) exp_rdma_q.push_back(d); // Whole pair.
  else exp_tcp_q.push_back(d.req_2);                       // Network side only.
endtask

task automatic check_rdma(input dreq_t got);
  dreq_t exp;
  assert (exp_rdma_q.size() > 0)
    else note_error("m_req_0 delivered a request that was never sent to RDMA");
  if (exp_rdma_q.size() > 0) begin
    exp = exp_rdma_q.pop_front(); // Oldest RDMA request first.
    assert (got == exp)
      else note_error($sformatf("Error m_req_0_data got %h exp %h", got, exp));
  end
endtask

task automatic check_tcp(input req_t got);
  req_t exp;
  assert (exp_tcp_q.size() > 0)
    else note_error("m_req_1 delivered a request that was never sent to TCP");
  if (exp_tcp_q.size() > 0) begin
    exp = exp_tcp_q.pop_front();
    assert (got == exp)
      else note_error($sformatf("Error m_req_1_data got %h exp %h", got, exp));
  end
endtask

// Served source against the alternating prediction.
task automatic check_rr(input bit src);
  assert (src == rr_next)
    else note_error($sformatf("Error s_req_%0d_ready got 1 exp 0", src));
  rr_next = ~src; // Priority passes to the other source.
endtask

`endif

// File: verification/tb_net_req.sv
/*
 * Testbench for the request steering stage.
 * Random host traffic and sink back-pressure, checked against a queue model.
 */

`timescale 1ns/1ps

module tb_net_req;

  import net_req_pkg::*;

  logic        aclk;
  logic        arst_n;
  logic [1:0]  src_valid;      // Host offers.
  logic [1:0]  host_rdy;       // Host readies from the DUT.
  dreq_t       src_data [2];
  logic        m_req_0_valid;
  logic        m_req_0_ready;
  dreq_t       m_req_0_data;
  logic        m_req_1_valid;
  logic        m_req_1_ready;
  req_t        m_req_1_data;

  int unsigned errors;
  int unsigned tests;
  int unsigned cyc;            // Edges since reset release.
  int unsigned seq [2];        // Per-source sequence number sent in len.
  bit [1:0]    taken;          // Offer accepted at the last edge.
  int unsigned offer_pct;      // Chance of a new offer per cycle.
  int unsigned ready_pct [2];  // Chance of sink ready per cycle.
  bit          rdma_only;
  bit          rr_check;
  int unsigned rr_count;
  bit          lat_check;
  bit          lat_seen;
  int unsigned in_cyc;         // Edge of the last host transfer.
  int unsigned blocked_cyc;    // Edges in a row with both hosts stalled.
  bit          hold_0;
  bit          hold_1;
  dreq_t       held_0;
  req_t        held_1;

  `include "net_req_model.svh"

  net_req_top uut (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .s_req_0_valid (src_valid[0]),
    .s_req_0_ready (host_rdy[0]),
    .s_req_0_data  (src_data[0]),
    .s_req_1_valid (src_valid[1]),
    .s_req_1_ready (host_rdy[1]),
    .s_req_1_data  (src_data[1]),
    .m_req_0_valid (m_req_0_valid),
    .m_req_0_ready (m_req_0_ready),
    .m_req_0_data  (m_req_0_data),
    .m_req_1_valid (m_req_1_valid),
    .m_req_1_ready (m_req_1_ready),
    .m_req_1_data  (m_req_1_data)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk; // 100 ns period.
  end

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic report(input string name, input int unsigned start);
    tests++;
    $display("%s: %0d errors", name, errors - start);
  endtask

  // Random descriptor tagged with its source and sequence number.
  function automatic req_t make_desc(input int src, input strm_t strm);
    req_t r;
    r.strm  = strm;
    r.vfid  = VFID_BITS'(src);
    r.dest  = DEST_BITS'($urandom);
    r.vaddr = {16'($urandom), 32'($urandom)};
    r.len   = LEN_BITS'(seq[src]);
    r.last  = 1'($urandom);
    return r;
  endfunction

  task automatic new_offer(input int src, input strm_t strm);
    dreq_t d;
    d.req_1        = make_desc(src, strm_t'($urandom_range(3)));
    d.req_2        = make_desc(src, strm); // Steering field.
    src_data[src]  = d;
    src_valid[src] = 1'b1;
    seq[src]++;
  endtask

  // One falling edge of stimulus for both hosts and both sinks.
  task automatic step();
    @(negedge aclk);
    for (int i = 0; i < 2; i++) begin
      if (src_valid[i] && taken[i]) src_valid[i] = 1'b0; // Offer done.
      taken[i] = 1'b0;
      if (!src_valid[i] && $urandom_range(99) < offer_pct)
        new_offer(i, rdma_only ? STRM_RDMA : strm_t'($urandom_range(3)));
    end
    m_req_0_ready = $urandom_range(99) < ready_pct[0];
    m_req_1_ready = $urandom_range(99) < ready_pct[1];
  endtask

  function automatic bit idle();
    return src_valid == 2'b00 && !m_req_0_valid && !m_req_1_valid &&
           exp_rdma_q.size() == 0 && exp_tcp_q.size() == 0;
  endfunction

  // No new offers and all sinks ready until nothing is left in flight.
  task automatic drain();
    int n;
    offer_pct    = 0;
    ready_pct[0] = 100;
    ready_pct[1] = 100;
    for (n = 0; n < 50 && !idle(); n++) step();
    assert (idle())
      else note_error($sformatf("Drain timed out with %0d RDMA and %0d TCP requests left",
                                exp_rdma_q.size(), exp_tcp_q.size()));
  endtask

  task automatic check_out_idle();
    assert (!m_req_0_valid)
      else note_error($sformatf("Error m_req_0_valid got %h exp 0", m_req_0_valid));
    assert (!m_req_1_valid)
      else note_error($sformatf("Error m_req_1_valid got %h exp 0", m_req_1_valid));
  endtask

  task automatic check_held(input string name, input logic valid,
                            input logic [173:0] got, input logic [173:0] exp);
    assert (valid)
      else note_error($sformatf("Error %s_valid got %h exp 1", name, valid));
    assert (got == exp)
      else note_error($sformatf("Error %s_data got %h exp %h", name, got, exp));
  endtask

  task automatic check_latency(input string name);
    if (lat_check) begin
      assert (cyc == in_cyc + 1)
        else note_error($sformatf("Error %s delay got %h exp 1", name, cyc - in_cyc));
      lat_seen = 1'b1;
    end
  endtask

  // Monitor samples every link on the rising edge.
  always @(posedge aclk) begin
    if (arst_n) begin
      cyc = cyc + 1;
      for (int i = 0; i < 2; i++) begin
        if (src_valid[i] && host_rdy[i]) begin
          taken[i] = 1'b1;
          in_cyc   = cyc;
          log_host(src_data[i]);
          if (rr_check) begin
            check_rr(i[0]);
            rr_count++;
          end
        end
      end
      if (src_valid == 2'b11 && host_rdy == 2'b00) blocked_cyc++;
      else blocked_cyc = 0;
      if (hold_0) check_held("m_req_0", m_req_0_valid, m_req_0_data, held_0);
      if (hold_1) check_held("m_req_1", m_req_1_valid, 174'(m_req_1_data), 174'(held_1));
      hold_0 = m_req_0_valid && !m_req_0_ready; // Stalled output must hold at the next edge.
      hold_1 = m_req_1_valid && !m_req_1_ready;
      held_0 = m_req_0_data;
      held_1 = m_req_1_data;
      if (m_req_0_valid && m_req_0_ready) begin
        check_rdma(m_req_0_data);
        check_latency("m_req_0_valid");
      end
      if (m_req_1_valid && m_req_1_ready) begin
        check_tcp(m_req_1_data);
        check_latency("m_req_1_valid");
      end
    end
  end

  initial begin
    int unsigned start;
    int          n;
    void'($urandom(42505)); // Fixed seed for the whole run.
    arst_n        = 1'b0;
    src_valid     = 2'b00;
    src_data[0]   = '0;
    src_data[1]   = '0;
    m_req_0_ready = 1'b0;
    m_req_1_ready = 1'b0;
    errors        = 0;
    tests         = 0;
    cyc           = 0;
    seq[0]        = 0;
    seq[1]        = 0;
    taken         = 2'b00;
    offer_pct     = 0;
    ready_pct[0]  = 100;
    ready_pct[1]  = 100;
    rdma_only     = 1'b0;
    rr_check      = 1'b0;
    lat_check     = 1'b0;
    hold_0        = 1'b0;
    hold_1        = 1'b0;
    blocked_cyc   = 0;

    // Outputs stay quiet in and right after reset.
    start = errors;
    repeat (5) begin
      @(negedge aclk);
      check_out_idle();
    end
    arst_n = 1'b1;
    @(negedge aclk);
    check_out_idle();
    report("reset_state", start);

    // Both hosts always offering with sinks always ready.
    start     = errors;
    rr_next   = 1'b0; // Source 0 first after reset.
    rr_count  = 0;
    rr_check  = 1'b1;
    offer_pct = 100;
    for (n = 0; n < 40 && rr_count < 8; n++) step();
    rr_check = 1'b0;
    assert (rr_count >= 8)
      else note_error($sformatf("Round-robin saw only %0d grants before timeout", rr_count));
    drain();
    report("round_robin", start);

    // Single request into empty slices for each destination.
    start = errors;
    for (int i = 0; i < 2; i++) begin
      step();
      new_offer(i, i == 0 ? STRM_RDMA : STRM_TCP);
      lat_seen  = 1'b0;
      lat_check = 1'b1;
      for (n = 0; n < 20 && !lat_seen; n++) step();
      lat_check = 1'b0;
      assert (lat_seen)
        else note_error($sformatf("Request from source %0d never reached its output", i));
    end
    drain();
    report("latency", start);

    // Mixed streams with random back-pressure.
    start        = errors;
    offer_pct    = 60;
    ready_pct[0] = 70;
    ready_pct[1] = 70;
    repeat (400) step();
    drain();
    report("random_traffic", start);

    // RDMA sink stalled until the slice fills and both hosts stall.
    start        = errors;
    rdma_only    = 1'b1;
    offer_pct    = 100;
    ready_pct[0] = 0;
    ready_pct[1] = 100;
    for (n = 0; n < 40 && blocked_cyc < 4; n++) step();
    assert (blocked_cyc >= 4)
      else note_error("Host readies never dropped while the RDMA output was stalled");
    rdma_only = 1'b0;
    drain();
    report("backpressure", start);

    $display("Summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+verification
hdl/net_req_pkg.sv
hdl/meta_reg.sv
hdl/dreq_arb_2_1.sv
hdl/dreq_mux_net_1_2.sv
hdl/net_req_top.sv
verification/tb_net_req.sv
